// File: src.f
design/core_pkg.sv
design/mem_port_if.sv
design/pipe_stage_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/mem_stage.sv
design/hazard_ctrl.sv
design/mini_core.sv
verification/core_props.sv
verification/core_tb_mem.sv
verification/core_tb.sv

// File: verification/core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb;

    localparam int          CLK_PERIOD    = 100;
    localparam int          RESET_CYCLES  = 10;
    localparam logic [31:0] RESET_PC      = 32'h0000_0100;
    localparam logic [31:0] SEED          = 32'h5da7_a595;
    localparam int          CYCLE_LIMIT   = 12;
    // Instruction count of all programs with NOP padding
    localparam int          INSTR_TOTAL   = 2 * 18 + 7 + 35 + 5 + 4 + 11;
    localparam int          PROGRAM_COUNT = 8;
    localparam int          WATCHDOG_CYCLES =
        INSTR_TOTAL * CYCLE_LIMIT + PROGRAM_COUNT * (RESET_CYCLES + 40);

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] mem_addr_o;
    logic        mem_rd_o;
    logic        mem_wr_o;
    logic [31:0] mem_wdata_o;
    logic [31:0] mem_rdata_i;
    logic        mem_ready_i;

    int          errors;
    int          checks;
    logic [31:0] prog_addr;
    int          prog_len;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];

    mini_core #(.RESET_PC(RESET_PC)) dut0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .mem_addr_o(mem_addr_o), .mem_rd_o(mem_rd_o), .mem_wr_o(mem_wr_o),
        .mem_wdata_o(mem_wdata_o), .mem_rdata_i(mem_rdata_i), .mem_ready_i(mem_ready_i)
    );

    core_tb_mem #(.SEED(SEED)) mem0 (
        .clk_i(clk_i), .addr_i(mem_addr_o), .rd_i(mem_rd_o), .wr_i(mem_wr_o),
        .wdata_i(mem_wdata_o), .rdata_o(mem_rdata_i), .ready_o(mem_ready_i)
    );

    bind mini_core core_props props0 (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .addr_i(mem_addr_o), .rd_i(mem_rd_o),
        .wr_i(mem_wr_o), .wdata_i(mem_wdata_o), .ready_i(mem_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, core_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, core_pkg::OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, core_pkg::OPC_LOAD};
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], core_pkg::OPC_STORE};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem0.write_word(prog_addr, word);
        prog_addr = prog_addr + 32'd4;
        prog_len++;
    endtask

    task automatic emit_padded(input logic [31:0] word, input int gap);
        emit(word);
        repeat (gap) emit(core_pkg::NOP_INSTR);
    endtask

    // Sum of three random 12-bit immediates built with an ADDI chain
    task automatic load_random(input logic [4:0] rd, output logic [31:0] value);
        logic [31:0] rnd;
        value = '0;
        for (int i = 0; i < 3; i++) begin
            rnd = $urandom;
            emit(addi(rd, (i == 0) ? 5'd0 : rd, rnd[11:0]));
            value = value + sext12(rnd[11:0]);
        end
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Program runs
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_program();
        @(posedge clk_i);
        #5;
        rst_n_i = 1'b0;
        @(posedge clk_i);
        #5;
        mem0.fill_nops();
        mem0.clear_log();
        prog_addr = RESET_PC;
        prog_len  = 0;
    endtask

    task automatic release_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #5;
        rst_n_i = 1'b1;
    endtask

    task automatic run_and_compare();
        int cycles;
        int limit;
        cycles = 0;
        limit  = prog_len * CYCLE_LIMIT + 20;
        release_reset();
        while (mem0.log_size() < exp_addr.size() && cycles < limit) begin
            @(posedge clk_i);
            cycles++;
        end
        if (mem0.log_size() < exp_addr.size()) begin
            errors++;
            $display("Error at %0t ns: only %0d of %0d expected stores arrived in time",
                     $time, mem0.log_size(), exp_addr.size());
        end else begin
            for (int i = 0; i < exp_addr.size(); i++) begin
                check_value($sformatf("log_addr[%0d]", i), mem0.logged_addr(i), exp_addr[i]);
                check_value($sformatf("log_data[%0d]", i), mem0.logged_data(i), exp_data[i]);
            end
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_outputs();
        begin_program();
        check_value("mem_rd_o", 32'(mem_rd_o), 32'd0);
        check_value("mem_wr_o", 32'(mem_wr_o), 32'd0);
        release_reset();
        #1;
        check_value("mem_rd_o", 32'(mem_rd_o), 32'd0);
        check_value("mem_wr_o", 32'(mem_wr_o), 32'd0);
        // First cycle after release
        @(posedge clk_i);
        #5;
        check_value("mem_rd_o", 32'(mem_rd_o), 32'd1);
        check_value("mem_addr_o", mem_addr_o, RESET_PC);
    endtask

    task automatic alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res [6];
        begin_program();
        load_random(5'd1, a);
        load_random(5'd2, b);
        emit(r_type(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
        emit(r_type(7'h20, 3'b000, 5'd11, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b111, 5'd12, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b110, 5'd13, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b100, 5'd14, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b010, 5'd15, 5'd1, 5'd2));
        res[0] = a + b;
        res[1] = a - b;
        res[2] = a & b;
        res[3] = a | b;
        res[4] = a ^ b;
        res[5] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        for (int i = 0; i < 6; i++) begin
            emit(sw(5'(10 + i), 5'd0, 12'(4 * i)));
            expect_store(32'(4 * i), res[i]);
        end
        run_and_compare();
    endtask

    // Same chain run back to back and then spaced by NOPs
    task automatic dependent_chain();
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] x2;
        logic [31:0] x4;
        logic [31:0] first_data [$];
        rnd = $urandom;
        a   = sext12(rnd[11:0]);
        x2  = a + a;
        x4  = x2 + sext12(rnd[27:16]) - a;
        for (int run = 0; run < 2; run++) begin
            begin_program();
            emit_padded(addi(5'd1, 5'd0, rnd[11:0]), run * 4);
            emit_padded(r_type(7'h00, 3'b000, 5'd2, 5'd1, 5'd1), run * 4);
            emit_padded(addi(5'd3, 5'd2, rnd[27:16]), run * 4);
            emit_padded(r_type(7'h20, 3'b000, 5'd4, 5'd3, 5'd1), run * 4);
            emit_padded(r_type(7'h00, 3'b110, 5'd5, 5'd4, 5'd2), run * 4);
            emit_padded(sw(5'd5, 5'd0, 12'h010), run * 4);
            emit_padded(sw(5'd4, 5'd0, 12'h014), run * 4);
            expect_store(32'h10, x4 | x2);
            expect_store(32'h14, x4);
            run_and_compare();
            if (run == 0) begin
                for (int i = 0; i < mem0.log_size(); i++) begin
                    first_data.push_back(mem0.logged_data(i));
                end
            end else begin
                for (int i = 0; i < first_data.size() && i < mem0.log_size(); i++) begin
                    check_value($sformatf("padded log_data[%0d]", i), mem0.logged_data(i),
                                first_data[i]);
                end
            end
        end
    endtask

    task automatic store_then_load();
        logic [31:0] rnd;
        rnd = $urandom;
        begin_program();
        emit(addi(5'd1, 5'd0, rnd[11:0]));
        emit(sw(5'd1, 5'd0, 12'h040));
        emit(lw(5'd2, 5'd0, 12'h040));
        emit(r_type(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(sw(5'd3, 5'd0, 12'h044));
        expect_store(32'h40, sext12(rnd[11:0]));
        expect_store(32'h44, sext12(rnd[11:0]) + sext12(rnd[11:0]));
        run_and_compare();
    endtask

    task automatic x0_writes();
        begin_program();
        emit(addi(5'd1, 5'd0, 12'h055));
        emit(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd1));
        emit(addi(5'd0, 5'd0, 12'h123));
        emit(sw(5'd0, 5'd0, 12'h048));
        expect_store(32'h48, 32'd0);
        run_and_compare();
    endtask

    // Base 0x80 plus offsets of -128 to 124 stays inside the data area
    task automatic store_order();
        logic [31:0] rnd;
        logic [31:0] vals [4];
        logic [11:0] off;
        begin_program();
        emit(addi(5'd5, 5'd0, 12'h080));
        for (int r = 0; r < 4; r++) begin
            rnd = $urandom;
            emit(addi(5'(6 + r), 5'd0, rnd[11:0]));
            vals[r] = sext12(rnd[11:0]);
        end
        for (int s = 0; s < 6; s++) begin
            rnd = $urandom;
            off = {{4{rnd[5]}}, rnd[5:0], 2'b00};
            emit(sw(5'(6 + s % 4), 5'd5, off));
            expect_store(32'h80 + sext12(off), vals[s % 4]);
        end
        run_and_compare();
    endtask

    initial begin
        rst_n_i   = 1'b0;
        errors    = 0;
        checks    = 0;
        prog_addr = RESET_PC;
        prog_len  = 0;
        reset_outputs();
        alu_ops();
        alu_ops();
        dependent_chain();
        store_then_load();
        x0_writes();
        store_order();
        errors = errors + dut0.props0.failures;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/core_tb_mem.sv
`timescale 1ns/1ns
`default_nettype none

module core_tb_mem #(
    parameter int          WORDS = 1024,
    parameter logic [31:0] SEED  = 32'h5da7_a595
) (
    input  wire         clk_i,
    input  wire  [31:0] addr_i,
    input  wire         rd_i,
    input  wire         wr_i,
    input  wire  [31:0] wdata_i,
    output logic [31:0] rdata_o,
    output logic        ready_o
);

    localparam int AW = $clog2(WORDS);

    logic [31:0] words [WORDS];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    int          delay;
    logic        waiting;

    initial begin
        void'($urandom(SEED));
        rdata_o = '0;
        ready_o = 1'b0;
        waiting = 1'b0;
        delay   = 0;
    end

    // Requests come from registers, so they are settled 5 ns after the edge
    always @(posedge clk_i) begin
        #5;
        if (!(rd_i || wr_i)) begin
            ready_o <= 1'b0;
            waiting = 1'b0;
        end else begin
            if (!waiting) begin
                delay   = $urandom_range(3, 0);
                waiting = 1'b1;
            end else if (delay != 0) begin
                delay--;
            end
            ready_o <= (delay == 0);
            rdata_o <= words[addr_i[AW+1:2]];
            if (delay == 0) begin
                waiting = 1'b0;
                // Completed write, the ready cycle is the one that counts
                if (wr_i) begin
                    words[addr_i[AW+1:2]] = wdata_i;
                    log_addr.push_back(addr_i);
                    log_data.push_back(wdata_i);
                end
            end
        end
    end

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        words[addr[AW+1:2]] = data;
    endtask

    task automatic fill_nops();
        for (int i = 0; i < WORDS; i++) begin
            words[i] = core_pkg::NOP_INSTR;
        end
    endtask

    task automatic clear_log();
        log_addr.delete();
        log_data.delete();
    endtask

    function automatic int log_size();
        return log_addr.size();
    endfunction

    function automatic logic [31:0] logged_addr(input int idx);
        return log_addr[idx];
    endfunction

    function automatic logic [31:0] logged_data(input int idx);
        return log_data[idx];
    endfunction

endmodule

`default_nettype wire

// File: verification/core_props.sv
`timescale 1ns/1ns
`default_nettype none

module core_props (
    input wire        clk_i,
    input wire        rst_n_i,
    input wire [31:0] addr_i,
    input wire        rd_i,
    input wire        wr_i,
    input wire [31:0] wdata_i,
    input wire        ready_i
);

    int failures = 0;

    // A waiting request keeps its kind until ready
    a_req_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rd_i || wr_i) && !ready_i |=> (rd_i == $past(rd_i)) && (wr_i == $past(wr_i))
    ) else begin
        failures++;
        $error("memory request dropped before ready");
    end

    a_req_stable: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        (rd_i || wr_i) && !ready_i |=> $stable(addr_i) && $stable(wdata_i)
    ) else begin
        failures++;
        $error("memory address or write data changed while waiting");
    end

    a_rd_wr_excl: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(rd_i && wr_i)
    ) else begin
        failures++;
        $error("memory read and write requested together");
    end

    // Checks the reset state itself
    a_idle_in_reset: assert property (
        @(posedge clk_i) !rst_n_i |-> !rd_i && !wr_i
    ) else begin
        failures++;
        $error("memory request active during reset");
    end

endmodule

`default_nettype wire

// File: design/mini_core.sv
`timescale 1ns/1ns
`default_nettype none

module mini_core #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    output logic [core_pkg::XLEN-1:0]   mem_addr_o,
    output logic                        mem_rd_o,
    output logic                        mem_wr_o,
    output logic [core_pkg::XLEN-1:0]   mem_wdata_o,
    input  wire  [core_pkg::XLEN-1:0]   mem_rdata_i,
    input  wire                         mem_ready_i
);

    mem_port_if if_port (.clk_i(clk_i));
    mem_port_if dm_port (.clk_i(clk_i));

    logic                        if_valid, id_valid, dec_valid, ex_valid, mem_valid, wb_valid;
    core_pkg::if_id_t            if_data, id_data;
    core_pkg::id_ex_t            dec_data, ex_data;
    core_pkg::ex_mem_t           exe_data, mem_data;
    core_pkg::mem_wb_t           mem_out, wb_data;
    logic [core_pkg::REG_AW-1:0] rs1_addr, rs2_addr;
    logic [core_pkg::XLEN-1:0]   rs1_data, rs2_data;
    logic                        rs1_used, rs2_used;
    logic                        mem_busy;
    logic                        hold_if, hold_id, hold_ex, bubble_ex, bubble_wb;
    logic                        dm_sel;
    logic                        owner_q;
    logic                        busy_q;

    ////////////////////////////////////////////////////////////////////////////
    // Memory port arbiter
    ////////////////////////////////////////////////////////////////////////////

    // Owner only changes between requests, data side wins when free
    assign dm_sel = busy_q ? owner_q : (dm_port.req_rd || dm_port.req_wr);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            owner_q <= 1'b0;
        end else begin
            busy_q  <= (mem_rd_o || mem_wr_o) && !mem_ready_i;
            owner_q <= dm_sel;
        end
    end

    assign mem_addr_o  = dm_sel ? dm_port.req_addr  : if_port.req_addr;
    assign mem_rd_o    = dm_sel ? dm_port.req_rd    : if_port.req_rd;
    assign mem_wr_o    = dm_sel ? dm_port.req_wr    : if_port.req_wr;
    assign mem_wdata_o = dm_sel ? dm_port.req_wdata : if_port.req_wdata;

    assign if_port.rsp_rdata = mem_rdata_i;
    assign dm_port.rsp_rdata = mem_rdata_i;
    assign if_port.rsp_ready = mem_ready_i && !dm_sel;
    assign dm_port.rsp_ready = mem_ready_i && dm_sel;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////////

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .mem(if_port),
        .stall_i(hold_if), .valid_o(if_valid), .data_o(if_data)
    );

    pipe_stage_reg #(.PAYLOAD_T(core_pkg::if_id_t)) u_if_id (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(if_valid), .data_i(if_data),
        .hold_i(hold_if), .bubble_i(1'b0), .valid_o(id_valid), .data_o(id_data)
    );

    decode_stage u_decode (
        .valid_i(id_valid), .data_i(id_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_used_o(rs1_used), .rs2_used_o(rs2_used),
        .valid_o(dec_valid), .data_o(dec_data)
    );

    register_file u_regfile (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .raddr_a_i(rs1_addr), .rdata_a_o(rs1_data),
        .raddr_b_i(rs2_addr), .rdata_b_o(rs2_data),
        .we_i(wb_valid && wb_data.we), .waddr_i(wb_data.dst), .wdata_i(wb_data.result)
    );

    pipe_stage_reg #(.PAYLOAD_T(core_pkg::id_ex_t)) u_id_ex (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(dec_valid), .data_i(dec_data),
        .hold_i(hold_id), .bubble_i(bubble_ex), .valid_o(ex_valid), .data_o(ex_data)
    );

    execute_stage u_execute (.data_i(ex_data), .data_o(exe_data));

    pipe_stage_reg #(.PAYLOAD_T(core_pkg::ex_mem_t)) u_ex_mem (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(ex_valid), .data_i(exe_data),
        .hold_i(hold_ex), .bubble_i(1'b0), .valid_o(mem_valid), .data_o(mem_data)
    );

    mem_stage u_mem (
        .valid_i(mem_valid), .data_i(mem_data), .mem(dm_port),
        .busy_o(mem_busy), .data_o(mem_out)
    );

    pipe_stage_reg #(.PAYLOAD_T(core_pkg::mem_wb_t)) u_mem_wb (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .valid_i(mem_valid), .data_i(mem_out),
        .hold_i(1'b0), .bubble_i(bubble_wb), .valid_o(wb_valid), .data_o(wb_data)
    );

    hazard_ctrl u_hazard (
        .id_valid_i(id_valid), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_used_i(rs1_used), .rs2_used_i(rs2_used),
        .ex_valid_i(ex_valid), .ex_dst_i(ex_data.dst), .ex_we_i(ex_data.we),
        .mem_valid_i(mem_valid), .mem_dst_i(mem_data.dst), .mem_we_i(mem_data.we),
        .wb_valid_i(wb_valid), .wb_dst_i(wb_data.dst), .wb_we_i(wb_data.we),
        .mem_busy_i(mem_busy),
        .hold_if_o(hold_if), .hold_id_o(hold_id), .hold_ex_o(hold_ex),
        .bubble_ex_o(bubble_ex), .bubble_wb_o(bubble_wb)
    );

endmodule

`default_nettype wire

// File: design/hazard_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl (
    input  wire                          id_valid_i,
    input  wire  [core_pkg::REG_AW-1:0]  rs1_addr_i,
    input  wire  [core_pkg::REG_AW-1:0]  rs2_addr_i,
    input  wire                          rs1_used_i,
    input  wire                          rs2_used_i,
    input  wire                          ex_valid_i,
    input  wire  [core_pkg::REG_AW-1:0]  ex_dst_i,
    input  wire                          ex_we_i,
    input  wire                          mem_valid_i,
    input  wire  [core_pkg::REG_AW-1:0]  mem_dst_i,
    input  wire                          mem_we_i,
    input  wire                          wb_valid_i,
    input  wire  [core_pkg::REG_AW-1:0]  wb_dst_i,
    input  wire                          wb_we_i,
    input  wire                          mem_busy_i,
    output logic                         hold_if_o,
    output logic                         hold_id_o,
    output logic                         hold_ex_o,
    output logic                         bubble_ex_o,
    output logic                         bubble_wb_o
);

    function automatic logic pending(input logic [core_pkg::REG_AW-1:0] rs);
        return (ex_valid_i && ex_we_i && (ex_dst_i == rs))
            || (mem_valid_i && mem_we_i && (mem_dst_i == rs))
            || (wb_valid_i && wb_we_i && (wb_dst_i == rs));
    endfunction

    logic raw;

    assign raw = id_valid_i
        && ((rs1_used_i && (rs1_addr_i != '0) && pending(rs1_addr_i))
         || (rs2_used_i && (rs2_addr_i != '0) && pending(rs2_addr_i)));

    // hold_X freezes the register after stage X, bubble_X empties the one before X
    assign hold_if_o   = mem_busy_i || raw;
    assign hold_id_o   = mem_busy_i;
    assign hold_ex_o   = mem_busy_i;
    assign bubble_ex_o = !mem_busy_i && raw;
    assign bubble_wb_o = mem_busy_i;

endmodule

`default_nettype wire

// File: design/mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage (
    input  wire                 valid_i,
    input  core_pkg::ex_mem_t   data_i,
    mem_port_if.requester       mem,
    output logic                busy_o,
    output core_pkg::mem_wb_t   data_o
);

    logic rd_req;
    logic wr_req;

    // EX/MEM is held during the access, which keeps the request stable
    assign rd_req = valid_i && data_i.is_load;
    assign wr_req = valid_i && data_i.is_store;

    assign mem.req_addr  = data_i.result;
    assign mem.req_rd    = rd_req;
    assign mem.req_wr    = wr_req;
    assign mem.req_wdata = data_i.store_data;

    assign busy_o = (rd_req || wr_req) && !mem.rsp_ready;

    // Load data is only valid in the ready cycle, when busy_o is low
    assign data_o.result = data_i.is_load ? mem.rsp_rdata : data_i.result;
    assign data_o.dst    = data_i.dst;
    assign data_o.we     = data_i.we;

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  core_pkg::id_ex_t  data_i,
    output core_pkg::ex_mem_t data_o
);

    logic [core_pkg::XLEN-1:0] alu_res;

    // Loads and stores come in as ALU_ADD, so the sum is the address
    always_comb begin
        case (data_i.alu_op)
            core_pkg::ALU_SUB: alu_res = data_i.op_a - data_i.op_b;
            core_pkg::ALU_AND: alu_res = data_i.op_a & data_i.op_b;
            core_pkg::ALU_OR:  alu_res = data_i.op_a | data_i.op_b;
            core_pkg::ALU_XOR: alu_res = data_i.op_a ^ data_i.op_b;
            core_pkg::ALU_SLT: begin
                alu_res = {31'd0, $signed(data_i.op_a) < $signed(data_i.op_b)};
            end
            default:           alu_res = data_i.op_a + data_i.op_b;
        endcase
    end

    assign data_o.result     = alu_res;
    assign data_o.store_data = data_i.store_data;
    assign data_o.dst        = data_i.dst;
    assign data_o.we         = data_i.we;
    assign data_o.is_load    = data_i.is_load;
    assign data_o.is_store   = data_i.is_store;

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
    input  wire                          clk_i,
    input  wire                          rst_n_i,
    input  wire  [core_pkg::REG_AW-1:0]  raddr_a_i,
    output logic [core_pkg::XLEN-1:0]    rdata_a_o,
    input  wire  [core_pkg::REG_AW-1:0]  raddr_b_i,
    output logic [core_pkg::XLEN-1:0]    rdata_b_o,
    input  wire                          we_i,
    input  wire  [core_pkg::REG_AW-1:0]  waddr_i,
    input  wire  [core_pkg::XLEN-1:0]    wdata_i
);

    logic [core_pkg::XLEN-1:0] regs_q [32];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs_q[raddr_a_i];
    assign rdata_b_o = regs_q[raddr_b_i];

endmodule

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  wire                             valid_i,
    input  core_pkg::if_id_t                data_i,
    output logic [core_pkg::REG_AW-1:0]     rs1_addr_o,
    output logic [core_pkg::REG_AW-1:0]     rs2_addr_o,
    input  wire  [core_pkg::XLEN-1:0]       rs1_data_i,
    input  wire  [core_pkg::XLEN-1:0]       rs2_data_i,
    output logic                            rs1_used_o,
    output logic                            rs2_used_o,
    output logic                            valid_o,
    output core_pkg::id_ex_t                data_o
);

    logic [core_pkg::XLEN-1:0] instr;
    logic [6:0]                opcode;
    logic [2:0]                funct3;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic                      is_op;
    logic                      is_op_imm;
    logic                      is_load;
    logic                      is_store;
    logic                      legal;

    // Empty slots decode as a NOP so nothing downstream reacts
    assign instr  = valid_i ? data_i.instr : core_pkg::NOP_INSTR;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    assign is_op     = (opcode == core_pkg::OPC_OP);
    assign is_op_imm = (opcode == core_pkg::OPC_OP_IMM) && (funct3 == 3'b000);
    assign is_load   = (opcode == core_pkg::OPC_LOAD) && (funct3 == 3'b010);
    assign is_store  = (opcode == core_pkg::OPC_STORE) && (funct3 == 3'b010);

    always_comb begin
        data_o.alu_op = core_pkg::ALU_ADD;
        legal         = is_op_imm || is_load || is_store;
        if (is_op) begin
            legal = 1'b1;
            case (funct3)
                3'b000:  data_o.alu_op = instr[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
                3'b010:  data_o.alu_op = core_pkg::ALU_SLT;
                3'b100:  data_o.alu_op = core_pkg::ALU_XOR;
                3'b110:  data_o.alu_op = core_pkg::ALU_OR;
                3'b111:  data_o.alu_op = core_pkg::ALU_AND;
                default: legal = 1'b0;
            endcase
        end
    end

    assign rs1_addr_o = instr[19:15];
    assign rs2_addr_o = instr[24:20];
    assign rs1_used_o = legal;
    assign rs2_used_o = legal && (is_op || is_store);

    // Unknown opcodes leave the pipe as empty slots
    assign valid_o           = valid_i && legal;
    assign data_o.op_a       = rs1_data_i;
    assign data_o.op_b       = is_op ? rs2_data_i : (is_store ? imm_s : imm_i);
    assign data_o.store_data = rs2_data_i;
    assign data_o.dst        = instr[11:7];
    assign data_o.we         = legal && !is_store;
    assign data_o.is_load    = is_load;
    assign data_o.is_store   = is_store;

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage #(
    parameter logic [core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  wire                clk_i,
    input  wire                rst_n_i,
    mem_port_if.requester      mem,
    input  wire                stall_i,
    output logic               valid_o,
    output core_pkg::if_id_t   data_o
);

    logic [core_pkg::XLEN-1:0] pc_q;
    logic                      req_q;
    logic                      buf_valid_q;
    logic [core_pkg::XLEN-1:0] buf_instr_q;
    logic                      fetch_done;

    assign fetch_done = req_q && mem.rsp_ready;

    assign mem.req_addr  = pc_q;
    assign mem.req_rd    = req_q;
    assign mem.req_wr    = 1'b0;
    assign mem.req_wdata = '0;

    // Buffered word first, else the word returning this cycle
    assign valid_o      = buf_valid_q || fetch_done;
    assign data_o.instr = buf_valid_q ? buf_instr_q : mem.rsp_rdata;
    assign data_o.pc    = pc_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q        <= RESET_PC;
            req_q       <= 1'b0;
            buf_valid_q <= 1'b0;
        end else if (valid_o && !stall_i) begin
            // Word taken by IF/ID, next request right away
            pc_q        <= pc_q + 32'd4;
            req_q       <= 1'b1;
            buf_valid_q <= 1'b0;
        end else if (fetch_done) begin
            // Returned during a stall, park it
            req_q       <= 1'b0;
            buf_valid_q <= 1'b1;
        end else if (!buf_valid_q) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fetch_done) begin
            buf_instr_q <= mem.rsp_rdata;
        end
    end

endmodule

`default_nettype wire

// File: design/pipe_stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_stage_reg #(
    parameter type PAYLOAD_T = logic
) (
    input  wire      clk_i,
    input  wire      rst_n_i,
    input  wire      valid_i,
    input  PAYLOAD_T data_i,
    input  wire      hold_i,
    input  wire      bubble_i,
    output logic     valid_o,
    output PAYLOAD_T data_o
);

    // Hold wins over bubble, bubble wins over load
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (hold_i) begin
            valid_o <= valid_o;
        end else if (bubble_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // Payload is don't care while invalid
    always_ff @(posedge clk_i) begin
        if (!hold_i) begin
            data_o <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_port_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mem_port_if (
    input wire clk_i
);

    logic [core_pkg::XLEN-1:0] req_addr;
    logic                      req_rd;
    logic                      req_wr;
    logic [core_pkg::XLEN-1:0] req_wdata;
    logic [core_pkg::XLEN-1:0] rsp_rdata;
    logic                      rsp_ready;

    // Request held with stable address and data until rsp_ready
    modport requester (
        input  clk_i,
        output req_addr, req_rd, req_wr, req_wdata,
        input  rsp_rdata, rsp_ready
    );

    modport arbiter (
        input  clk_i,
        input  req_addr, req_rd, req_wr, req_wdata,
        output rsp_rdata, rsp_ready
    );

endinterface

`default_nettype wire

// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    // Datapath widths
    parameter int XLEN   = 32;
    parameter int REG_AW = 5;

    // RV32I major opcodes of the supported subset
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LOAD   = 7'b0000011;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;

    // ADDI x0, x0, 0
    parameter logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
    } if_id_t;

    typedef struct packed {
        alu_op_e           alu_op;
        logic [XLEN-1:0]   op_a;
        logic [XLEN-1:0]   op_b;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] dst;
        logic              we;
        logic              is_load;
        logic              is_store;
    } id_ex_t;

    typedef struct packed {
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] dst;
        logic              we;
        logic              is_load;
        logic              is_store;
    } ex_mem_t;

    typedef struct packed {
        logic [XLEN-1:0]   result;
        logic [REG_AW-1:0] dst;
        logic              we;
    } mem_wb_t;

endpackage

`default_nettype wire
